// ==== rtl/hci_mem_if.sv ====
`default_nettype none

interface hci_mem_if;
  import hci_source_pkg::*;

  logic      req;      // read request
  logic      gnt;      // request accepted
  addr_t     add;      // word aligned byte address
  logic      r_valid;  // response present
  mem_data_t r_data;   // 64 bit read data
  logic      r_ready;  // response consumed

  // streamer side
  modport initiator (
    output req,
    output add,
    output r_ready,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  // memory side
  modport target (
    input  req,
    input  add,
    input  r_ready,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

`default_nettype wire

// ==== rtl/hci_source_pkg.sv ====
`default_nettype none

package hci_source_pkg;

  localparam int unsigned ADDR_WIDTH      = 32; // byte address
  localparam int unsigned MEM_DW          = 64; // one word wider than the stream
  localparam int unsigned STREAM_DW       = 32;
  localparam int unsigned CNT_WIDTH       = 16; // beat and transaction counters
  localparam int unsigned ADDR_FIFO_DEPTH = 2;
  localparam int unsigned OFFS_FIFO_DEPTH = 8;  // max outstanding reads

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [1:0]            offs_t;        // byte offset in a word
  typedef logic [MEM_DW-1:0]     mem_data_t;
  typedef logic [STREAM_DW-1:0]  stream_data_t;
  typedef logic [CNT_WIDTH-1:0]  cnt_t;

  // job configuration, 112 bits
  typedef struct packed {
    addr_t base_addr;  // first byte address
    cnt_t  tot_len;    // beats in the job
    cnt_t  d0_len;     // beats per row
    cnt_t  d0_stride;  // byte step inside a row
    addr_t d1_stride;  // byte step from row start to row start
  } src_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    WORKING,
    DONE
  } streamer_state_t;

endpackage

`default_nettype wire

// ==== rtl/hci_source_streamer.sv ====
`default_nettype none

module hci_source_streamer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         enable_i,
  input  logic                         start_i,
  input  hci_source_pkg::src_cfg_t     cfg_i,
  output logic                         ready_start_o,
  output logic                         done_o,
  output logic                         gen_en_o,
  output logic                         gen_clr_o,
  input  logic                         gen_done_i,
  input  logic                         addr_valid_i,
  input  hci_source_pkg::addr_t        addr_i,
  output logic                         addr_ready_o,
  input  logic                         addr_empty_i,
  output logic                         offs_valid_o,
  output hci_source_pkg::offs_t        offs_o,
  input  logic                         offs_valid_i,
  input  hci_source_pkg::offs_t        offs_i,
  output logic                         offs_ready_o,
  hci_mem_if.initiator                 mem,
  output logic                         stream_valid_o,
  input  logic                         stream_ready_i,
  output hci_source_pkg::stream_data_t stream_data_o
);
  import hci_source_pkg::*;

  streamer_state_t state_q, state_d;
  logic      hold_valid_q;  // response parked under back-pressure
  mem_data_t hold_data_q;
  mem_data_t resp_data;     // live or parked response
  cnt_t      beat_cnt_q;
  logic      beat_cnt_clr;
  logic      beat;
  logic      active;

  assign active = state_q != IDLE;

  // request side, one read per popped address
  assign mem.req      = active & enable_i & addr_valid_i & stream_ready_i; // no req when sink stalls
  assign mem.add      = active ? {addr_i[ADDR_WIDTH-1:2], 2'b00} : '0; // word aligned
  assign addr_ready_o = mem.req & mem.gnt;
  assign offs_valid_o = mem.req & mem.gnt; // offset queued on every accepted req
  assign offs_o       = addr_i[1:0];

  // response side
  assign mem.r_ready    = stream_ready_i;
  assign resp_data      = mem.r_valid ? mem.r_data : hold_data_q;
  assign stream_valid_o = enable_i & offs_valid_i & (mem.r_valid | hold_valid_q);
  assign stream_data_o  = resp_data[{offs_i, 3'b000} +: STREAM_DW]; // lane at byte offset
  assign beat           = stream_valid_o & stream_ready_i;
  assign offs_ready_o   = beat; // one offset per beat

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (enable_i) begin
      if (mem.r_valid && stream_ready_i) begin
        hold_valid_q <= 1'b0; // passed straight through
      end else if (mem.r_valid) begin
        hold_valid_q <= 1'b1; // sink stalled, park it
      end else if (hold_valid_q && stream_ready_i) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enable_i && mem.r_valid) begin
      hold_data_q <= mem.r_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (clear_i || beat_cnt_clr) begin
      beat_cnt_q <= '0;
    end else if (enable_i && beat) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else if (enable_i) begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    ready_start_o = 1'b0;
    done_o        = 1'b0;
    gen_en_o      = 1'b0;
    gen_clr_o     = clear_i;
    beat_cnt_clr  = 1'b0;
    case (state_q)
      IDLE: begin
        ready_start_o = 1'b1;
        if (start_i && enable_i) begin
          state_d  = WORKING;
          gen_en_o = 1'b1;
        end
      end
      WORKING: begin
        gen_en_o = 1'b1;
        if (gen_done_i) begin
          state_d = DONE; // all addresses issued to the FIFO
        end
      end
      DONE: begin
        gen_en_o = 1'b1;
        if (enable_i && addr_empty_i && beat_cnt_q == cfg_i.tot_len) begin
          state_d      = IDLE;
          done_o       = 1'b1; // single cycle, state leaves DONE
          gen_en_o     = 1'b0;
          gen_clr_o    = 1'b1;
          beat_cnt_clr = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/hci_source_top.sv ====
`default_nettype none

module hci_source_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         enable_i,
  input  logic                         start_i,
  input  hci_source_pkg::addr_t        base_addr_i,
  input  hci_source_pkg::cnt_t         tot_len_i,
  input  hci_source_pkg::cnt_t         d0_len_i,
  input  hci_source_pkg::cnt_t         d0_stride_i,
  input  hci_source_pkg::addr_t        d1_stride_i,
  output logic                         ready_start_o,
  output logic                         done_o,
  output logic                         mem_req_o,
  output hci_source_pkg::addr_t        mem_add_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_r_valid_i,
  input  hci_source_pkg::mem_data_t    mem_r_data_i,
  output logic                         mem_r_ready_o,
  output logic                         stream_valid_o,
  input  logic                         stream_ready_i,
  output hci_source_pkg::stream_data_t stream_data_o
);
  import hci_source_pkg::*;

  src_cfg_t cfg;
  logic     gen_en, gen_clr, gen_done;
  logic     gen_valid, gen_ready;
  addr_t    gen_addr;
  logic     addr_valid, addr_ready, addr_empty;
  addr_t    addr;
  logic     offs_push_valid, offs_pop_valid, offs_pop_ready;
  offs_t    offs_push, offs_pop;

  hci_mem_if u_mem_if ();

  assign cfg = '{base_addr: base_addr_i, tot_len: tot_len_i, d0_len: d0_len_i,
                 d0_stride: d0_stride_i, d1_stride: d1_stride_i};

  // memory port out to plain pins
  assign mem_req_o        = u_mem_if.req;
  assign mem_add_o        = u_mem_if.add;
  assign mem_r_ready_o    = u_mem_if.r_ready;
  assign u_mem_if.gnt     = mem_gnt_i;
  assign u_mem_if.r_valid = mem_r_valid_i;
  assign u_mem_if.r_data  = mem_r_data_i;

  source_addrgen u_addrgen (
    .clk_i, .rst_ni,
    .clear_i(gen_clr), .enable_i(gen_en), .presample_i(start_i), .cfg_i(cfg),
    .addr_valid_o(gen_valid), .addr_ready_i(gen_ready), .addr_o(gen_addr),
    .done_o(gen_done)
  );

  source_fifo #(.payload_t(addr_t), .DEPTH(ADDR_FIFO_DEPTH)) u_addr_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_valid_i(gen_valid), .push_data_i(gen_addr), .push_ready_o(gen_ready),
    .pop_valid_o(addr_valid), .pop_data_o(addr), .pop_ready_i(addr_ready),
    .empty_o(addr_empty)
  );

  // offsets of outstanding reads, sized to the max in flight
  source_fifo #(.payload_t(offs_t), .DEPTH(OFFS_FIFO_DEPTH)) u_offs_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_valid_i(offs_push_valid), .push_data_i(offs_push), .push_ready_o(),
    .pop_valid_o(offs_pop_valid), .pop_data_o(offs_pop), .pop_ready_i(offs_pop_ready),
    .empty_o()
  );

  hci_source_streamer u_streamer (
    .clk_i, .rst_ni, .clear_i, .enable_i, .start_i, .cfg_i(cfg),
    .ready_start_o, .done_o,
    .gen_en_o(gen_en), .gen_clr_o(gen_clr), .gen_done_i(gen_done),
    .addr_valid_i(addr_valid), .addr_i(addr), .addr_ready_o(addr_ready),
    .addr_empty_i(addr_empty),
    .offs_valid_o(offs_push_valid), .offs_o(offs_push),
    .offs_valid_i(offs_pop_valid), .offs_i(offs_pop), .offs_ready_o(offs_pop_ready),
    .mem(u_mem_if.initiator),
    .stream_valid_o, .stream_ready_i, .stream_data_o
  );

endmodule

`default_nettype wire

// ==== rtl/source_addrgen.sv ====
`default_nettype none

module source_addrgen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     enable_i,
  input  logic                     presample_i,
  input  hci_source_pkg::src_cfg_t cfg_i,
  output logic                     addr_valid_o,
  input  logic                     addr_ready_i,
  output hci_source_pkg::addr_t    addr_o,
  output logic                     done_o
);
  import hci_source_pkg::*;

  src_cfg_t cfg_q;        // job config sampled at start
  cnt_t     inner_cnt_q;  // beat index inside the row
  cnt_t     trans_cnt_q;  // accepted addresses
  addr_t    row_addr_q;   // first address of the row
  addr_t    cur_addr_q;   // address on offer
  logic     done_q;
  logic     accept;
  logic     last_trans;
  logic     last_inner;
  addr_t    next_row;

  assign accept     = addr_valid_o & addr_ready_i;
  assign last_trans = trans_cnt_q == cnt_t'(cfg_q.tot_len - 1'b1);
  assign last_inner = inner_cnt_q == cnt_t'(cfg_q.d0_len - 1'b1);
  assign next_row   = row_addr_q + cfg_q.d1_stride; // outer jump

  assign addr_valid_o = enable_i & ~done_q; // held until accepted
  assign addr_o       = cur_addr_q;
  assign done_o       = done_q;

  always_ff @(posedge clk_i) begin
    if (presample_i) begin
      cfg_q <= cfg_i; // config stays fixed for the job
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inner_cnt_q <= '0;
      trans_cnt_q <= '0;
      row_addr_q  <= '0;
      cur_addr_q  <= '0;
      done_q      <= 1'b1; // nothing to emit
    end else if (clear_i) begin
      inner_cnt_q <= '0;
      trans_cnt_q <= '0;
      row_addr_q  <= '0;
      cur_addr_q  <= '0;
      done_q      <= 1'b1;
    end else if (presample_i) begin
      inner_cnt_q <= '0;
      trans_cnt_q <= '0;
      row_addr_q  <= cfg_i.base_addr;
      cur_addr_q  <= cfg_i.base_addr;
      done_q      <= cfg_i.tot_len == '0; // empty job
    end else if (accept) begin
      trans_cnt_q <= trans_cnt_q + 1'b1;
      if (last_trans) begin
        done_q <= 1'b1; // level rises after last accept
      end else if (last_inner) begin
        inner_cnt_q <= '0;        // wrap to next row
        row_addr_q  <= next_row;
        cur_addr_q  <= next_row;
      end else begin
        inner_cnt_q <= inner_cnt_q + 1'b1;
        cur_addr_q  <= cur_addr_q + addr_t'(cfg_q.d0_stride); // inner step
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/source_fifo.sv ====
`default_nettype none

module source_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;  // buffer index
  typedef logic [$clog2(DEPTH+1)-1:0] occ_t;  // 0 to DEPTH entries

  payload_t mem_q [DEPTH];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  occ_t     count_q;
  logic     push;
  logic     pop;

  assign push_ready_o = count_q != occ_t'(DEPTH); // full blocks push
  assign pop_valid_o  = count_q != '0;
  assign empty_o      = count_q == '0;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/hci_source_pkg.sv
rtl/hci_mem_if.sv
rtl/source_addrgen.sv
rtl/source_fifo.sv
rtl/hci_source_streamer.sv
rtl/hci_source_top.sv
test/hci_source_checker.sv
test/tb_hci_source.sv

// ==== test/hci_source_checker.sv ====
`default_nettype none

module hci_source_checker (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         clear_i,
  input logic                         mem_req_o,
  input logic                         mem_gnt_i,
  input hci_source_pkg::addr_t        mem_add_o,
  input logic                         stream_valid_o,
  input logic                         stream_ready_i,
  input hci_source_pkg::stream_data_t stream_data_o,
  input logic                         ready_start_o,
  input logic                         done_o
);

  // address holds while the request waits for grant
  add_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i && !clear_i |=> $stable(mem_add_o))
    else begin
      $error("memory address changed while the request waited for grant");
      tb_hci_source.errors++;
    end

  // stalled beat keeps valid and data
  beat_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_valid_o && !stream_ready_i && !clear_i |=> stream_valid_o && $stable(stream_data_o))
    else begin
      $error("stream beat dropped or changed while waiting for ready");
      tb_hci_source.errors++;
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else begin
      $error("done_o stayed high for more than one cycle");
      tb_hci_source.errors++;
    end

  done_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> !ready_start_o) // done only on the way out of DONE
    else begin
      $error("done_o and ready_start_o high together");
      tb_hci_source.errors++;
    end

endmodule

`default_nettype wire

// ==== test/tb_hci_source.sv ====
`default_nettype none

module tb_hci_source;
  import hci_source_pkg::*;

  typedef struct packed {
    addr_t    base;
    cnt_t     tot_len;
    cnt_t     d0_len;
    cnt_t     d0_stride;
    addr_t    d1_stride;
    bit [7:0] stall_pct;  // chance of stream_ready_i low
    bit       clear_mid;  // clear_i halfway through
    bit       exp_done;   // done pulses expected
  } job_t;

  localparam int NUM_JOBS = 8;

  // base tot d0_len d0_stride d1_stride stall clear done
  job_t jobs [NUM_JOBS] = '{
    '{32'h1000, 16'd16, 16'd16, 16'd4,  32'd0,   8'd0,  1'b0, 1'b1},  // aligned 1D
    '{32'h2001, 16'd8,  16'd8,  16'd4,  32'd0,   8'd0,  1'b0, 1'b1},  // offset 1
    '{32'h3002, 16'd8,  16'd8,  16'd4,  32'd0,   8'd10, 1'b0, 1'b1},  // offset 2
    '{32'h4003, 16'd8,  16'd8,  16'd4,  32'd0,   8'd10, 1'b0, 1'b1},  // offset 3
    '{32'h5000, 16'd24, 16'd4,  16'd4,  32'd64,  8'd0,  1'b0, 1'b1},  // 2D jump
    '{32'h6005, 16'd40, 16'd5,  16'd8,  32'd102, 8'd50, 1'b0, 1'b1},  // 2D under stalls
    '{32'h7000, 16'd32, 16'd32, 16'd4,  32'd0,   8'd30, 1'b1, 1'b0},  // cleared mid-job
    '{32'h8002, 16'd12, 16'd3,  16'd12, 32'd40,  8'd50, 1'b0, 1'b1}   // runs after clear
  };

  logic         clk_i, rst_ni, clear_i, enable_i, start_i;
  addr_t        base_addr_i, d1_stride_i;
  cnt_t         tot_len_i, d0_len_i, d0_stride_i;
  logic         ready_start_o, done_o;
  logic         mem_req_o, mem_gnt_i, mem_r_valid_i, mem_r_ready_o;
  addr_t        mem_add_o;
  mem_data_t    mem_r_data_i;
  logic         stream_valid_o, stream_ready_i;
  stream_data_t stream_data_o;

  stream_data_t exp_data_q [$];  // expected beats of the running job
  addr_t        exp_addr_q [$];  // expected word addresses
  mem_data_t    resp_data_q [$]; // granted reads in flight
  int           resp_due_q [$];
  int           beat_idx, req_idx, done_cnt, errors, cur_job, now, stall_pct;
  bit           after_clear;

  hci_source_top DUT (.*);

  bind hci_source_top hci_source_checker u_checker (.*);

  function automatic logic [7:0] byte_at(addr_t a);
    return 8'((a * 7) + 3); // memory content rule
  endfunction

  function automatic mem_data_t word_at(addr_t a);
    mem_data_t w;
    for (int k = 0; k < 8; k++) begin
      w[8*k +: 8] = byte_at(a + addr_t'(k));
    end
    return w;
  endfunction

  task automatic report_fail(string msg);
    errors++;
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(string name, stream_data_t exp, stream_data_t act);
    if (act !== exp) report_fail($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) report_fail($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_cnt(string name, cnt_t exp, cnt_t act);
    if (act !== exp) report_fail($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) report_fail($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
  endtask

  // in-order read memory with random grant and latency, plus the sink's ready
  task automatic memory_model();
    forever begin
      @(posedge clk_i);
      now++;
      if (!rst_ni || clear_i) begin
        resp_data_q.delete(); // reads in flight are dropped on clear
        resp_due_q.delete();
      end else begin
        check_flag($sformatf("job %0d r_ready", cur_job), stream_ready_i, mem_r_ready_o);
        if (mem_r_valid_i && mem_r_ready_o) begin
          void'(resp_data_q.pop_front());
          void'(resp_due_q.pop_front());
        end
        if (mem_req_o && mem_gnt_i) begin
          if (req_idx >= exp_addr_q.size()) report_fail("memory request beyond tot_len");
          else check_addr($sformatf("job %0d req %0d", cur_job, req_idx),
                          exp_addr_q[req_idx], mem_add_o);
          req_idx++;
          resp_data_q.push_back(word_at(mem_add_o));
          resp_due_q.push_back(now + int'($urandom_range(4, 1)));
        end
      end
      mem_gnt_i      <= (resp_data_q.size() < OFFS_FIFO_DEPTH) && ($urandom_range(99) < 70);
      stream_ready_i <= ($urandom_range(99) >= stall_pct);
      if (resp_data_q.size() > 0 && resp_due_q[0] <= now) begin
        mem_r_valid_i <= 1'b1; // held until r_ready
        mem_r_data_i  <= resp_data_q[0];
      end else begin
        mem_r_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic stream_sink();
    forever begin
      @(posedge clk_i);
      if (rst_ni && stream_valid_o && stream_ready_i) begin
        if (after_clear) report_fail("stream beat seen after clear_i");
        else if (beat_idx >= exp_data_q.size()) report_fail("stream beat beyond tot_len");
        else check_data($sformatf("job %0d beat %0d", cur_job, beat_idx),
                        exp_data_q[beat_idx], stream_data_o);
        beat_idx++;
      end
      if (clear_i) after_clear = 1'b1;
      if (done_o) begin
        check_cnt($sformatf("job %0d beats at done", cur_job),
                  cnt_t'(exp_data_q.size()), cnt_t'(beat_idx));
        done_cnt++;
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin : watchdog
    int unsigned limit;
    limit = 1000;
    foreach (jobs[n]) limit += jobs[n].tot_len * 20; // cycles per beat allowance
    repeat (limit) @(posedge clk_i);
    report_fail("timeout, the jobs did not finish in the allowed cycles");
  end

  initial begin : assertion_watch
    wait (errors != 0);
    report_fail("an assertion in the bound checker failed");
  end

  initial begin : main
    job_t  j;
    addr_t a;
    void'($urandom(32'h60df56af));
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    start_i        = 1'b0;
    mem_gnt_i      = 1'b0;
    mem_r_valid_i  = 1'b0;
    stream_ready_i = 1'b0;
    enable_i       = 1'b1;
    base_addr_i    = '0;
    tot_len_i      = '0;
    d0_len_i       = '0;
    d0_stride_i    = '0;
    d1_stride_i    = '0;
    mem_r_data_i   = '0;
    fork // children inherit the seeded generator
      memory_model();
      stream_sink();
    join_none
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_flag("ready_start after reset", 1'b1, ready_start_o);
    foreach (jobs[n]) begin
      j = jobs[n];
      exp_data_q.delete();
      exp_addr_q.delete();
      for (int i = 0; i < j.tot_len; i++) begin
        a = j.base + addr_t'(i / j.d0_len) * j.d1_stride + addr_t'((i % j.d0_len) * j.d0_stride);
        exp_addr_q.push_back({a[31:2], 2'b00});
        exp_data_q.push_back({byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)});
      end
      beat_idx    = 0;
      req_idx     = 0;
      done_cnt    = 0;
      cur_job     = n;
      after_clear = 1'b0;
      stall_pct   = j.stall_pct;
      base_addr_i <= j.base;
      tot_len_i   <= j.tot_len;
      d0_len_i    <= j.d0_len;
      d0_stride_i <= j.d0_stride;
      d1_stride_i <= j.d1_stride;
      start_i     <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      if (j.clear_mid) begin
        while (beat_idx < j.tot_len / 2) @(posedge clk_i);
        clear_i <= 1'b1;
        @(posedge clk_i);
        clear_i <= 1'b0;
        repeat (20) begin
          @(posedge clk_i);
          check_flag($sformatf("job %0d stream_valid after clear", n), 1'b0, stream_valid_o);
        end
      end else begin
        while (done_cnt == 0) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
        check_cnt($sformatf("job %0d beats", n), j.tot_len, cnt_t'(beat_idx));
      end
      check_cnt($sformatf("job %0d done pulses", n), cnt_t'(j.exp_done), cnt_t'(done_cnt));
      check_flag($sformatf("job %0d ready_start after job", n), 1'b1, ready_start_o);
    end
    repeat (5) @(posedge clk_i);
    if (errors == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      report_fail("errors were recorded during the run");
    end
  end

endmodule

`default_nettype wire
